//--- all.f
+incdir+include
src/minmax_pkg.sv
src/fp_classify.sv
src/minmax_lane.sv
src/simd_result_packer.sv
src/minmax_slice.sv
dv/tb_minmax_slice.sv

//--- include/minmax_ref_model.svh
// Reference model of the SIMD min/max slice
// IEEE minNum/maxNum per lane, ones in every unused result bit and
// the invalid flag collected over the masked active lanes
`ifndef MINMAX_REF_MODEL_SVH
`define MINMAX_REF_MODEL_SVH

function automatic logic nan_in_fmt(input logic [31:0] x, input fp_format_e fmt);
  if (fmt == FP16) begin
    return (x[14:10] == 5'h1f) && (|x[9:0]);
  end
  return (x[30:23] == 8'hff) && (|x[22:0]);
endfunction

function automatic logic snan_in_fmt(input logic [31:0] x, input fp_format_e fmt);
  return nan_in_fmt(x, fmt) && !((fmt == FP16) ? x[9] : x[22]);  // Quiet bit clear
endfunction

// True when a sits strictly below b for two non-NaN values
function automatic logic strictly_below(input logic [31:0] a, b, input fp_format_e fmt);
  logic        sa, sb;
  logic [30:0] ma, mb;
  sa = (fmt == FP16) ? a[15] : a[31];
  sb = (fmt == FP16) ? b[15] : b[31];
  ma = (fmt == FP16) ? {16'h0000, a[14:0]} : a[30:0];
  mb = (fmt == FP16) ? {16'h0000, b[14:0]} : b[30:0];
  if (sa != sb) begin
    return sa;  // Any negative value including -0 is below any positive one
  end
  return sa ? (ma > mb) : (ma < mb);
endfunction

function automatic logic [31:0] lane_minmax(input logic [31:0] a, b, input fp_format_e fmt,
                                            input logic is_max);
  if (nan_in_fmt(a, fmt) && nan_in_fmt(b, fmt)) begin
    return (fmt == FP16) ? {16'h0000, FP16_CANON_NAN} : FP32_CANON_NAN;
  end
  if (nan_in_fmt(a, fmt)) return b;
  if (nan_in_fmt(b, fmt)) return a;
  if (is_max) return strictly_below(a, b, fmt) ? b : a;
  return strictly_below(b, a, fmt) ? b : a;
endfunction

function automatic int active_lanes(input fp_format_e fmt, input logic vec);
  if (!vec) return 1;
  return (fmt == FP16) ? 4 : 2;
endfunction

// Slice i of a word with FP16 values in the low half
function automatic logic [31:0] lane_slice(input logic [DATA_WIDTH-1:0] w, input int i,
                                           input fp_format_e fmt);
  if (fmt == FP16) begin
    return {16'h0000, w[16*i +: 16]};
  end
  return w[32*i +: 32];
endfunction

function automatic logic [DATA_WIDTH-1:0] expected_word(input logic [DATA_WIDTH-1:0] a, b,
    input fp_format_e fmt, input logic is_max, input logic vec);
  logic [DATA_WIDTH-1:0] r;
  logic [31:0]           lane_r;
  r = '1;
  for (int i = 0; i < active_lanes(fmt, vec); i++) begin
    lane_r = lane_minmax(lane_slice(a, i, fmt), lane_slice(b, i, fmt), fmt, is_max);
    if (fmt == FP16) begin
      r[16*i +: 16] = lane_r[15:0];
    end else begin
      r[32*i +: 32] = lane_r;
    end
  end
  return r;
endfunction

function automatic status_t expected_status(input logic [DATA_WIDTH-1:0] a, b,
    input fp_format_e fmt, input logic vec, input logic [NUM_LANES-1:0] mask);
  status_t st;
  st = '0;
  for (int i = 0; i < active_lanes(fmt, vec); i++) begin
    if (mask[i] && (snan_in_fmt(lane_slice(a, i, fmt), fmt) ||
                    snan_in_fmt(lane_slice(b, i, fmt), fmt))) begin
      st.nv = 1'b1;
    end
  end
  return st;
endfunction

`endif

//--- dv/tb_minmax_slice.sv
// Testbench for the SIMD min/max slice
// Directed scalar, vector and back-to-back operations with each result
// checked against the reference model two cycles after its strobe

`timescale 1ns/100ps
`default_nettype none

module tb_minmax_slice;

  import minmax_pkg::*;

  `include "minmax_ref_model.svh"

  localparam int unsigned SEED           = 32'h30e2640b;
  localparam int          RESET_CYCLES   = 8;
  localparam int          MAX_OPS        = 48;  // Upper bound on strobes below
  localparam int          CYCLES_PER_OP  = 4;
  localparam int          TIMEOUT_CYCLES = 10 * (RESET_CYCLES + MAX_OPS * CYCLES_PER_OP);

  logic                  clk_i;
  logic                  rst_i;
  logic                  in_valid_i;
  logic [DATA_WIDTH-1:0] operand_a_i;
  logic [DATA_WIDTH-1:0] operand_b_i;
  fp_format_e            fmt_i;
  logic                  op_max_i;
  logic                  vectorial_i;
  logic [NUM_LANES-1:0]  simd_mask_i;
  logic [TAG_WIDTH-1:0]  tag_i;
  logic                  out_valid_o;
  logic [DATA_WIDTH-1:0] result_o;
  status_t               status_o;
  logic [TAG_WIDTH-1:0]  tag_o;
  logic                  busy_o;

  logic [TAG_WIDTH-1:0]  next_tag;
  int                    cycle_count = 0;

  minmax_slice dut0 (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Run stopped after %0d cycles before all tests finished", cycle_count);
      $display("Simulation FAILED");
      $fatal(1);
    end
  end

  // ----------------------------------------------------------------------
  // Compare tasks
  // ----------------------------------------------------------------------
  task automatic check_result(input logic [DATA_WIDTH-1:0] got, exp);
    if (got !== exp) begin
      $display("mismatch result_o: got %h expected %h", got, exp);
      $display("Simulation FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_status(input status_t got, exp);
    if (got !== exp) begin
      $display("mismatch status_o: got %h expected %h", got, exp);
      $display("Simulation FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_tag(input logic [TAG_WIDTH-1:0] got, exp);
    if (got !== exp) begin
      $display("mismatch tag_o: got %h expected %h", got, exp);
      $display("Simulation FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_flag(input string name, input logic got, exp);
    if (got !== exp) begin
      $display("mismatch %s: got %h expected %h", name, got, exp);
      $display("Simulation FAILED");
      $fatal(1);
    end
  endtask

  // ----------------------------------------------------------------------
  // Stimulus helpers
  // ----------------------------------------------------------------------
  function automatic logic [31:0] rand_fp32();
    return {1'($urandom), 8'($urandom_range(254, 1)), 23'($urandom)};  // Normal
  endfunction

  function automatic logic [15:0] rand_fp16();
    return {1'($urandom), 5'($urandom_range(30, 1)), 10'($urandom)};
  endfunction

  // Called right after a rising edge
  task automatic set_inputs(input logic [DATA_WIDTH-1:0] a, b, input fp_format_e fmt,
                            input logic is_max, vec, input logic [NUM_LANES-1:0] mask,
                            input logic [TAG_WIDTH-1:0] tag);
    in_valid_i  <= 1'b1;
    operand_a_i <= a;
    operand_b_i <= b;
    fmt_i       <= fmt;
    op_max_i    <= is_max;
    vectorial_i <= vec;
    simd_mask_i <= mask;
    tag_i       <= tag;
  endtask

  task automatic check_output(input logic [DATA_WIDTH-1:0] exp_res, input status_t exp_st,
                              input logic [TAG_WIDTH-1:0] exp_tag);
    check_flag("out_valid_o", out_valid_o, 1'b1);
    check_result(result_o, exp_res);
    check_status(status_o, exp_st);
    check_tag(tag_o, exp_tag);
  endtask

  task automatic run_single(input logic [DATA_WIDTH-1:0] a, b, input fp_format_e fmt,
                            input logic is_max, vec, input logic [NUM_LANES-1:0] mask);
    logic [TAG_WIDTH-1:0] tag;
    tag      = next_tag;
    next_tag = next_tag + 8'd1;
    @(posedge clk_i);
    set_inputs(a, b, fmt, is_max, vec, mask, tag);
    @(posedge clk_i);
    in_valid_i <= 1'b0;
    @(negedge clk_i);
    check_flag("out_valid_o", out_valid_o, 1'b0);  // Never one cycle early
    check_flag("busy_o", busy_o, 1'b1);
    @(posedge clk_i);
    @(negedge clk_i);
    check_output(expected_word(a, b, fmt, is_max, vec),
                 expected_status(a, b, fmt, vec, mask), tag);
  endtask

  // ----------------------------------------------------------------------
  // Directed tests
  // ----------------------------------------------------------------------
  task automatic do_scalar32(input logic [31:0] a, b, input logic is_max,
                             input logic [NUM_LANES-1:0] mask);
    run_single({$urandom, a}, {$urandom, b}, FP32, is_max, 1'b0, mask);
  endtask

  // Random upper bits must not reach the result
  task automatic do_scalar16(input logic [15:0] a, b, input logic is_max,
                             input logic [NUM_LANES-1:0] mask);
    run_single({48'({$urandom, $urandom}), a}, {48'({$urandom, $urandom}), b}, FP16,
               is_max, 1'b0, mask);
  endtask

  task automatic do_vector32(input logic [DATA_WIDTH-1:0] a, b, input logic is_max,
                             input logic [NUM_LANES-1:0] mask);
    run_single(a, b, FP32, is_max, 1'b1, mask);
  endtask

  task automatic do_vector16(input logic [DATA_WIDTH-1:0] a, b, input logic is_max,
                             input logic [NUM_LANES-1:0] mask);
    run_single(a, b, FP16, is_max, 1'b1, mask);
  endtask

  // Three strobes back to back with results on consecutive cycles
  task automatic do_pipelined();
    logic [DATA_WIDTH-1:0] op_a[3];
    logic [DATA_WIDTH-1:0] op_b[3];
    fp_format_e            fmt[3];
    logic                  vec[3];
    logic [TAG_WIDTH-1:0]  tag[3];
    op_a = '{{$urandom, rand_fp32()}, {rand_fp16(), rand_fp16(), rand_fp16(), rand_fp16()},
             {48'($urandom), rand_fp16()}};
    op_b = '{{$urandom, rand_fp32()}, {rand_fp16(), rand_fp16(), rand_fp16(), rand_fp16()},
             {48'($urandom), 16'h7c01}};
    fmt  = '{FP32, FP16, FP16};
    vec  = '{1'b0, 1'b1, 1'b0};
    for (int i = 0; i < 3; i++) begin
      tag[i]   = next_tag;
      next_tag = next_tag + 8'd1;
    end
    for (int c = 0; c < 6; c++) begin
      @(posedge clk_i);
      if (c < 3) begin
        set_inputs(op_a[c], op_b[c], fmt[c], c[0], vec[c], 4'b1111, tag[c]);
      end else if (c == 3) begin
        in_valid_i <= 1'b0;
      end
      @(negedge clk_i);
      if (c >= 2 && c < 5) begin
        check_output(expected_word(op_a[c-2], op_b[c-2], fmt[c-2], c[0], vec[c-2]),
                     expected_status(op_a[c-2], op_b[c-2], fmt[c-2], vec[c-2], 4'b1111),
                     tag[c-2]);
      end else begin
        check_flag("out_valid_o", out_valid_o, 1'b0);
      end
      check_flag("busy_o", busy_o, (c >= 1 && c <= 4));
    end
  endtask

  initial begin
    void'($urandom(SEED));
    rst_i       = 1'b1;
    in_valid_i  = 1'b0;
    operand_a_i = '0;
    operand_b_i = '0;
    fmt_i       = FP32;
    op_max_i    = 1'b0;
    vectorial_i = 1'b0;
    simd_mask_i = '0;
    tag_i       = '0;
    next_tag    = 8'h01;
    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_i <= 1'b0;
    @(negedge clk_i);
    check_flag("out_valid_o", out_valid_o, 1'b0);
    check_flag("busy_o", busy_o, 1'b0);

    for (int i = 0; i < 6; i++) begin
      do_scalar32(rand_fp32(), rand_fp32(), i[0], 4'b0001);
    end
    do_scalar32(32'h8000_0000, 32'h0000_0000, 1'b0, 4'b0001);  // min(-0, +0) is -0
    do_scalar32(32'h0000_0000, 32'h8000_0000, 1'b0, 4'b0001);
    do_scalar32(32'h8000_0000, 32'h0000_0000, 1'b1, 4'b0001);

    do_scalar16(16'h7e01, 16'h3c00, 1'b0, 4'b0001);  // One quiet NaN
    do_scalar16(16'hc000, 16'hfe00, 1'b1, 4'b0001);
    do_scalar16(16'h7e00, 16'hffff, 1'b0, 4'b0001);  // Two NaNs
    do_scalar16(16'h7c01, 16'h7d00, 1'b1, 4'b0001);
    do_scalar16(16'h7c01, 16'h4000, 1'b1, 4'b0001);  // Signalling NaN
    do_scalar16(16'h4000, 16'h7c01, 1'b0, 4'b0000);
    for (int i = 0; i < 4; i++) begin
      do_scalar16(rand_fp16(), rand_fp16(), i[0], 4'b0001);
    end

    for (int i = 0; i < 4; i++) begin
      do_vector32({rand_fp32(), rand_fp32()}, {rand_fp32(), rand_fp32()}, i[0], 4'($urandom));
      do_vector16({rand_fp16(), rand_fp16(), rand_fp16(), rand_fp16()},
                  {rand_fp16(), rand_fp16(), rand_fp16(), rand_fp16()}, i[0], 4'($urandom));
    end
    do_vector32({32'h7f80_0001, rand_fp32()}, {rand_fp32(), rand_fp32()}, 1'b0, 4'b0001);
    do_vector32({32'h7f80_0001, rand_fp32()}, {rand_fp32(), rand_fp32()}, 1'b1, 4'b0010);
    do_vector16({16'h7c01, rand_fp16(), 16'h7e00, rand_fp16()},
                {rand_fp16(), rand_fp16(), rand_fp16(), rand_fp16()}, 1'b0, 4'b0111);
    do_vector16({16'h7c01, rand_fp16(), 16'h7e00, rand_fp16()},
                {rand_fp16(), rand_fp16(), rand_fp16(), rand_fp16()}, 1'b1, 4'b1000);

    do_pipelined();

    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the min/max slice testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f all.f --top-module tb_minmax_slice \
  -Mdir obj_dir -o sim_minmax > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_minmax > sim.log 2>&1
cat sim.log
grep -q "Simulation FAILED" sim.log && exit 1
grep -q "Simulation PASSED" sim.log || exit 1
exit 0

//--- src/fp_classify.sv
// Operand classifier for one lane
// Flags zero, NaN and signalling NaN in FP32 or FP16 (low half) and
// builds a key whose unsigned order matches the floating-point order

`timescale 1ns/100ps
`default_nettype none

module fp_classify (
  input  logic [minmax_pkg::FP32_WIDTH-1:0] value_i,
  input  minmax_pkg::fp_format_e            fmt_i,
  output logic                              sign_o,
  output logic                              is_zero_o,
  output logic                              is_nan_o,
  output logic                              is_snan_o,
  output logic [minmax_pkg::FP32_WIDTH-1:0] order_key_o
);

  import minmax_pkg::*;

  logic [FP32_WIDTH-1:0] aligned;  // Value moved to the top of the word
  logic                  exp_ones;
  logic                  exp_zero;
  logic                  man_zero;
  logic                  quiet_bit;

  always_comb begin
    if (fmt_i == FP16) begin
      aligned   = {value_i[FP16_WIDTH-1:0], 16'h0000};
      exp_ones  = &value_i[14:10];
      exp_zero  = ~|value_i[14:10];
      man_zero  = ~|value_i[9:0];
      quiet_bit = value_i[9];
    end else begin
      aligned   = value_i;
      exp_ones  = &value_i[30:23];
      exp_zero  = ~|value_i[30:23];
      man_zero  = ~|value_i[22:0];
      quiet_bit = value_i[22];
    end
  end

  assign sign_o    = aligned[FP32_WIDTH-1];
  assign is_zero_o = exp_zero & man_zero;
  assign is_nan_o  = exp_ones & ~man_zero;
  assign is_snan_o = is_nan_o & ~quiet_bit;  // Quiet bit clear

  // Negatives inverted so larger magnitude sorts lower and -0 lands just below +0
  assign order_key_o = sign_o ? ~aligned : {1'b1, aligned[FP32_WIDTH-2:0]};

endmodule

`default_nettype wire

//--- src/minmax_lane.sv
// One SIMD lane of the min/max slice
// Selects minNum or maxNum of two operands with IEEE NaN handling, then
// carries result, invalid flag and auxiliary data through the pipeline

`timescale 1ns/100ps
`default_nettype none

module minmax_lane #(
  parameter bit LANE_HAS_FP32 = 1'b1
) (
  input  logic                              clk_i,
  input  logic                              rst_i,
  input  logic                              lane_valid_i,
  input  logic [minmax_pkg::FP32_WIDTH-1:0] op_a_i,
  input  logic [minmax_pkg::FP32_WIDTH-1:0] op_b_i,
  input  minmax_pkg::fp_format_e            fmt_i,
  input  logic                              op_max_i,
  input  logic                              mask_i,
  input  minmax_pkg::fp_format_e            aux_fmt_i,
  input  logic                              aux_vec_i,
  input  logic [minmax_pkg::TAG_WIDTH-1:0]  aux_tag_i,
  output logic                              lane_valid_o,
  output logic [minmax_pkg::FP32_WIDTH-1:0] lane_result_o,
  output logic                              lane_nv_o,
  output minmax_pkg::fp_format_e            aux_fmt_o,
  output logic                              aux_vec_o,
  output logic [minmax_pkg::TAG_WIDTH-1:0]  aux_tag_o,
  output logic                              lane_busy_o
);

  import minmax_pkg::*;

  // Payload layout is {nv, result, fmt, vec, tag}
  localparam int unsigned PAY_W = 1 + FP32_WIDTH + 2 + TAG_WIDTH;

  fp_format_e            lane_fmt;
  logic                  a_sign, b_sign;
  logic                  a_zero, b_zero;
  logic                  a_nan, b_nan;
  logic                  a_snan, b_snan;
  logic [FP32_WIDTH-1:0] a_key, b_key;
  logic                  a_lt_b;
  logic [FP32_WIDTH-1:0] res_d;
  logic [PAY_W-1:0]      pay_d;

  logic [NUM_PIPE_REGS-1:0]            valid_q;
  logic [NUM_PIPE_REGS-1:0][PAY_W-1:0] pay_q;

  assign lane_fmt = LANE_HAS_FP32 ? fmt_i : FP16;  // Narrow lanes are FP16 only

  fp_classify i_class_a (
    .value_i     (op_a_i),
    .fmt_i       (lane_fmt),
    .sign_o      (a_sign),
    .is_zero_o   (a_zero),
    .is_nan_o    (a_nan),
    .is_snan_o   (a_snan),
    .order_key_o (a_key)
  );

  fp_classify i_class_b (
    .value_i     (op_b_i),
    .fmt_i       (lane_fmt),
    .sign_o      (b_sign),
    .is_zero_o   (b_zero),
    .is_nan_o    (b_nan),
    .is_snan_o   (b_snan),
    .order_key_o (b_key)
  );

  // ----------------------------------------------------------------------
  // Compare and select
  // ----------------------------------------------------------------------
  assign a_lt_b = (a_zero & b_zero) ? (a_sign & ~b_sign) : (a_key < b_key);

  always_comb begin
    if (a_nan & b_nan) begin
      res_d = (lane_fmt == FP16) ? {16'h0000, FP16_CANON_NAN} : FP32_CANON_NAN;
    end else if (a_nan) begin
      res_d = op_b_i;  // NaN loses against a number
    end else if (b_nan) begin
      res_d = op_a_i;
    end else begin
      res_d = (op_max_i ^ a_lt_b) ? op_a_i : op_b_i;
    end
  end

  assign pay_d = {(a_snan | b_snan) & mask_i, res_d, aux_fmt_i, aux_vec_i, aux_tag_i};

  // ----------------------------------------------------------------------
  // Pipeline stages
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= '0;
    end else begin
      valid_q[0] <= lane_valid_i;
      for (int i = 1; i < NUM_PIPE_REGS; i++) begin
        valid_q[i] <= valid_q[i-1];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (lane_valid_i) begin
      pay_q[0] <= pay_d;
    end
    for (int i = 1; i < NUM_PIPE_REGS; i++) begin
      if (valid_q[i-1]) begin
        pay_q[i] <= pay_q[i-1];  // Advance only with a valid operation
      end
    end
  end

  assign lane_valid_o  = valid_q[NUM_PIPE_REGS-1];
  assign lane_nv_o     = pay_q[NUM_PIPE_REGS-1][PAY_W-1];
  assign lane_result_o = pay_q[NUM_PIPE_REGS-1][PAY_W-2 -: FP32_WIDTH];
  assign aux_fmt_o     = fp_format_e'(pay_q[NUM_PIPE_REGS-1][TAG_WIDTH+1]);
  assign aux_vec_o     = pay_q[NUM_PIPE_REGS-1][TAG_WIDTH];
  assign aux_tag_o     = pay_q[NUM_PIPE_REGS-1][TAG_WIDTH-1:0];
  assign lane_busy_o   = |valid_q;

  // FP16-only lanes must never be started in FP32 mode
  a_fp32_support : assert property (@(posedge clk_i) disable iff (rst_i)
    (lane_valid_i && fmt_i == FP32) |-> LANE_HAS_FP32);

  a_fixed_latency : assert property (@(posedge clk_i) disable iff (rst_i)
    lane_valid_o == $past(lane_valid_i, NUM_PIPE_REGS));

endmodule

`default_nettype wire

//--- src/minmax_pkg.sv
// SIMD min/max slice shared definitions
// Formats, widths, latency, status flags and the 64-bit SIMD word views

`default_nettype none

package minmax_pkg;

  // ----------------------------------------------------------------------
  // Datapath geometry
  // ----------------------------------------------------------------------
  localparam int unsigned DATA_WIDTH    = 64;
  localparam int unsigned NUM_LANES     = 4;  // FP16 vector case
  localparam int unsigned NUM_PIPE_REGS = 2;  // Fixed lane latency
  localparam int unsigned TAG_WIDTH     = 8;

  // ----------------------------------------------------------------------
  // Formats
  // ----------------------------------------------------------------------
  typedef enum logic {
    FP32 = 1'b0,
    FP16 = 1'b1
  } fp_format_e;

  localparam int unsigned FP32_WIDTH = 32;
  localparam int unsigned FP16_WIDTH = 16;

  // Quiet NaNs returned when both inputs are NaN
  localparam logic [FP32_WIDTH-1:0] FP32_CANON_NAN = 32'h7fc0_0000;
  localparam logic [FP16_WIDTH-1:0] FP16_CANON_NAN = 16'h7e00;

  // IEEE exception flags of which min/max only ever raises nv
  typedef struct packed {
    logic nv;  // Invalid operation
    logic dz;  // Divide by zero
    logic of;  // Overflow
    logic uf;  // Underflow
    logic nx;  // Inexact
  } status_t;

  // One operand or result word, seen per format
  typedef union packed {
    logic [DATA_WIDTH/FP32_WIDTH-1:0][FP32_WIDTH-1:0] fp32;
    logic [DATA_WIDTH/FP16_WIDTH-1:0][FP16_WIDTH-1:0] fp16;
  } simd_word_u;

endpackage

`default_nettype wire

//--- src/minmax_slice.sv
// SIMD floating-point min/max slice
// Splits two 64-bit operand words into FP32 or FP16 lanes, runs one
// min/max lane per slice and packs the lane results into one word

`timescale 1ns/100ps
`default_nettype none

module minmax_slice (
  input  logic                              clk_i,
  input  logic                              rst_i,
  input  logic                              in_valid_i,
  input  logic [minmax_pkg::DATA_WIDTH-1:0] operand_a_i,
  input  logic [minmax_pkg::DATA_WIDTH-1:0] operand_b_i,
  input  minmax_pkg::fp_format_e            fmt_i,
  input  logic                              op_max_i,
  input  logic                              vectorial_i,
  input  logic [minmax_pkg::NUM_LANES-1:0]  simd_mask_i,
  input  logic [minmax_pkg::TAG_WIDTH-1:0]  tag_i,
  output logic                              out_valid_o,
  output logic [minmax_pkg::DATA_WIDTH-1:0] result_o,
  output minmax_pkg::status_t               status_o,
  output logic [minmax_pkg::TAG_WIDTH-1:0]  tag_o,
  output logic                              busy_o
);

  import minmax_pkg::*;

  simd_word_u op_a;
  simd_word_u op_b;

  logic [NUM_LANES-1:0]                 lane_valid_in;
  logic [NUM_LANES-1:0]                 lane_valid_out;
  logic [NUM_LANES-1:0][FP32_WIDTH-1:0] lane_a;
  logic [NUM_LANES-1:0][FP32_WIDTH-1:0] lane_b;
  logic [NUM_LANES-1:0][FP32_WIDTH-1:0] lane_res;
  logic [NUM_LANES-1:0]                 lane_nv;
  logic [NUM_LANES-1:0]                 lane_busy;
  fp_format_e                           res_fmt;  // Format carried by lane 0
  logic                                 res_vec;

  assign op_a = operand_a_i;
  assign op_b = operand_b_i;

  // ----------------------------------------------------------------------
  // Operand slicing and valid gating
  // ----------------------------------------------------------------------
  for (genvar lane = 0; lane < NUM_LANES; lane++) begin : gen_slice
    localparam bit HAS_FP32 = (lane < DATA_WIDTH / FP32_WIDTH);

    if (HAS_FP32) begin : gen_wide
      assign lane_a[lane] = (fmt_i == FP32) ? op_a.fp32[lane] : {16'h0000, op_a.fp16[lane]};
      assign lane_b[lane] = (fmt_i == FP32) ? op_b.fp32[lane] : {16'h0000, op_b.fp16[lane]};
    end else begin : gen_narrow
      assign lane_a[lane] = {16'h0000, op_a.fp16[lane]};
      assign lane_b[lane] = {16'h0000, op_b.fp16[lane]};
    end

    // Upper lanes start only for vectors in a format they support
    assign lane_valid_in[lane] = in_valid_i &
        ((lane == 0) | (vectorial_i & (HAS_FP32 | (fmt_i == FP16))));
  end

  // ----------------------------------------------------------------------
  // Lanes
  // ----------------------------------------------------------------------
  minmax_lane #(
    .LANE_HAS_FP32 (1'b1)
  ) i_lane0 (
    .clk_i,
    .rst_i,
    .lane_valid_i  (lane_valid_in[0]),
    .op_a_i        (lane_a[0]),
    .op_b_i        (lane_b[0]),
    .fmt_i,
    .op_max_i,
    .mask_i        (simd_mask_i[0]),
    .aux_fmt_i     (fmt_i),
    .aux_vec_i     (vectorial_i),
    .aux_tag_i     (tag_i),
    .lane_valid_o  (lane_valid_out[0]),
    .lane_result_o (lane_res[0]),
    .lane_nv_o     (lane_nv[0]),
    .aux_fmt_o     (res_fmt),
    .aux_vec_o     (res_vec),
    .aux_tag_o     (tag_o),
    .lane_busy_o   (lane_busy[0])
  );

  for (genvar lane = 1; lane < NUM_LANES; lane++) begin : gen_upper_lanes
    minmax_lane #(
      .LANE_HAS_FP32 (lane < DATA_WIDTH / FP32_WIDTH)
    ) i_lane (
      .clk_i,
      .rst_i,
      .lane_valid_i  (lane_valid_in[lane]),
      .op_a_i        (lane_a[lane]),
      .op_b_i        (lane_b[lane]),
      .fmt_i,
      .op_max_i,
      .mask_i        (simd_mask_i[lane]),
      .aux_fmt_i     (FP32),  // Aux travels in lane 0 only
      .aux_vec_i     (1'b0),
      .aux_tag_i     ('0),
      .lane_valid_o  (lane_valid_out[lane]),
      .lane_result_o (lane_res[lane]),
      .lane_nv_o     (lane_nv[lane]),
      .aux_fmt_o     (),
      .aux_vec_o     (),
      .aux_tag_o     (),
      .lane_busy_o   (lane_busy[lane])
    );
  end

  simd_result_packer i_packer (
    .lane_valid_i  (lane_valid_out),
    .lane_result_i (lane_res),
    .lane_nv_i     (lane_nv),
    .res_fmt_i     (res_fmt),
    .res_vec_i     (res_vec),
    .result_o,
    .status_o
  );

  assign out_valid_o = lane_valid_out[0];  // Lane 0 runs for every operation
  assign busy_o      = |lane_busy;

endmodule

`default_nettype wire

//--- src/simd_result_packer.sv
// Result packer of the min/max slice
// Places lane results into the 64-bit word for the result format,
// fills all bits without a valid lane with ones and collapses status

`timescale 1ns/100ps
`default_nettype none

module simd_result_packer (
  input  logic [minmax_pkg::NUM_LANES-1:0]                         lane_valid_i,
  input  logic [minmax_pkg::NUM_LANES-1:0][minmax_pkg::FP32_WIDTH-1:0] lane_result_i,
  input  logic [minmax_pkg::NUM_LANES-1:0]                         lane_nv_i,
  input  minmax_pkg::fp_format_e                                   res_fmt_i,
  input  logic                                                     res_vec_i,
  output logic [minmax_pkg::DATA_WIDTH-1:0]                        result_o,
  output minmax_pkg::status_t                                      status_o
);

  import minmax_pkg::*;

  logic [NUM_LANES-1:0] lane_used;  // Lane 0 always and upper lanes only for vectors

  assign lane_used = lane_valid_i & {{(NUM_LANES-1){res_vec_i}}, 1'b1};

  // ----------------------------------------------------------------------
  // Result assembly
  // ----------------------------------------------------------------------
  always_comb begin
    simd_word_u packed_word;
    packed_word = '1;  // NaN-box by default
    if (res_fmt_i == FP16) begin
      for (int i = 0; i < DATA_WIDTH / FP16_WIDTH; i++) begin
        if (lane_used[i]) begin
          packed_word.fp16[i] = lane_result_i[i][FP16_WIDTH-1:0];
        end
      end
    end else begin
      for (int i = 0; i < DATA_WIDTH / FP32_WIDTH; i++) begin
        if (lane_used[i]) begin
          packed_word.fp32[i] = lane_result_i[i];
        end
      end
    end
    result_o = packed_word;
  end

  // Lane nv arrives masked and counts only for used lanes
  always_comb begin
    status_o    = '0;
    status_o.nv = |(lane_nv_i & lane_used);
  end

  // Scalar results never come with an upper lane
  always_comb begin
    if (lane_valid_i[0] && !res_vec_i) begin
      a_scalar_single_lane : assert (lane_valid_i[NUM_LANES-1:1] == '0)
        else $error("Upper lane valid for a scalar result");
    end
  end

endmodule

`default_nettype wire
